// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 -Wno-fatal
TOP       = tb_uart
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== src.f ====
+incdir+.
uart_frame_pkg.sv
uart_ctrl_pkg.sv
uart_bit_if.sv
uart_baud_gen.sv
uart_fifo.sv
uart_ctrl.sv
uart_tx_shifter.sv
uart_rx_shifter.sv
uart_top.sv
tb_uart.sv

// ==== tb_uart.sv ====
// UART testbench replaying frame vectors from the stimulus file against uart_top
`timescale 1ns/1ns
`include "uart_config.svh"

module tb_uart;

    localparam int max_vectors = 32;
    localparam int fields      = 9;   // Words per vector line
    localparam int op_loop     = 1;
    localparam int op_line     = 2;
    localparam int op_err_par  = 3;
    localparam int op_err_stop = 4;
    localparam int op_overrun  = 5;

    logic                        clk;
    logic                        resetn;
    logic                        en;
    logic [`UART_PRESCALE_W-1:0] prescaler;
    uart_frame_pkg::parity_e     parity_mode;
    logic                        two_stop;
    logic                        loopback_en;
    logic                        wr;
    uart_frame_pkg::data_t       wdata;
    logic                        rd;
    logic                        tx_empty;
    logic                        tx_full;
    logic [`UART_FIFO_AW:0]      tx_level;
    uart_frame_pkg::data_t       rdata;
    logic                        rx_empty;
    logic                        rx_full;
    logic [`UART_FIFO_AW:0]      rx_level;
    logic                        parity_error_flag;
    logic                        frame_error_flag;
    logic                        overrun_flag;
    logic                        rx;
    logic                        tx;

    logic [15:0] vec_mem [0:max_vectors*fields-1];
    logic [31:0] lfsr;
    int          par_pulses;
    int          frm_pulses;
    int          ovr_pulses;
    int          cycles;
    int          cycle_limit;
    int          bit_clks;   // Clocks per serial bit
    string       test_name;

    uart_top dut (
        .clk               (clk),
        .resetn            (resetn),
        .en                (en),
        .prescaler         (prescaler),
        .parity_mode       (parity_mode),
        .two_stop          (two_stop),
        .loopback_en       (loopback_en),
        .wr                (wr),
        .wdata             (wdata),
        .rd                (rd),
        .tx_empty          (tx_empty),
        .tx_full           (tx_full),
        .tx_level          (tx_level),
        .rdata             (rdata),
        .rx_empty          (rx_empty),
        .rx_full           (rx_full),
        .rx_level          (rx_level),
        .parity_error_flag (parity_error_flag),
        .frame_error_flag  (frame_error_flag),
        .overrun_flag      (overrun_flag),
        .rx                (rx),
        .tx                (tx)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin
        if (resetn) begin
            if (parity_error_flag)
                par_pulses++;
            if (frame_error_flag)
                frm_pulses++;
            if (overrun_flag)
                ovr_pulses++;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit)
            stop_on_error("timeout: DUT did not finish");
    end

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_data(input string what, input uart_frame_pkg::data_t exp,
                              input uart_frame_pkg::data_t act);
        if (act !== exp)
            stop_on_error($sformatf("MISMATCH %s %s: expected %h, actual %h",
                                    test_name, what, exp, act));
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp)
            stop_on_error($sformatf("MISMATCH %s %s: expected %b, actual %b",
                                    test_name, what, exp, act));
    endtask

    task automatic check_level(input string what, input logic [`UART_FIFO_AW:0] exp,
                               input logic [`UART_FIFO_AW:0] act);
        if (act !== exp)
            stop_on_error($sformatf("MISMATCH %s %s: expected %0d, actual %0d",
                                    test_name, what, exp, act));
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp)
            stop_on_error($sformatf("MISMATCH %s %s: expected %0d, actual %0d",
                                    test_name, what, exp, act));
    endtask

    // Line value of the parity bit, from the count of ones in the word
    function automatic logic expected_parity(input uart_frame_pkg::parity_e mode,
                                             input uart_frame_pkg::data_t d);
        int ones;
        ones = 0;
        for (int i = 0; i < `UART_DATA_W; i++) begin
            if (d[i])
                ones++;
        end
        case (mode)
            uart_frame_pkg::par_odd:    return (ones % 2) == 0;   // Total ones made odd
            uart_frame_pkg::par_even:   return (ones % 2) == 1;
            uart_frame_pkg::par_stick1: return 1'b1;
            default:                    return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;   // Taps 32, 22, 2, 1
        return s >> 1;
    endfunction

    task automatic random_byte(output uart_frame_pkg::data_t b);
        uart_frame_pkg::data_t r;
        for (int i = 0; i < `UART_DATA_W; i++) begin
            lfsr = lfsr_step(lfsr);
            r[i] = lfsr[0];
        end
        b = r;
    endtask

    function automatic int field(input int v, input int f);
        return int'(vec_mem[v * fields + f]);
    endfunction

    task automatic reset_dut();
        resetn = 1'b0;
        en     = 1'b1;
        wr     = 1'b0;
        rd     = 1'b0;
        rx     = 1'b1;
        repeat (16) @(negedge clk);
        par_pulses = 0;
        frm_pulses = 0;
        ovr_pulses = 0;
        resetn     = 1'b1;
        @(negedge clk);
    endtask

    task automatic verify_reset_state();
        check_flag("tx idle", 1'b1, tx);
        check_flag("tx_empty", 1'b1, tx_empty);
        check_flag("rx_empty", 1'b1, rx_empty);
        check_level("tx_level", '0, tx_level);
        check_level("rx_level", '0, rx_level);
        check_flag("parity_error_flag", 1'b0, parity_error_flag);
        check_flag("frame_error_flag", 1'b0, frame_error_flag);
        check_flag("overrun_flag", 1'b0, overrun_flag);
    endtask

    task automatic push_byte(input uart_frame_pkg::data_t b);
        while (tx_full)
            @(negedge clk);
        wdata = b;
        wr    = 1'b1;
        @(negedge clk);
        wr = 1'b0;
    endtask

    task automatic read_and_compare(input uart_frame_pkg::data_t exp[$], input int count);
        for (int i = 0; i < count; i++) begin
            check_data($sformatf("rx byte %0d", i), exp[i], rdata);
            rd = 1'b1;   // Head advances on the next edge
            @(negedge clk);
        end
        rd = 1'b0;
        check_flag("rx_empty after reads", 1'b1, rx_empty);
    endtask

    // Samples tx at bit centers counted from the falling start edge
    task automatic sample_tx_frame(input uart_frame_pkg::data_t d);
        while (tx !== 1'b0)
            @(negedge clk);
        repeat (bit_clks / 2) @(negedge clk);
        check_flag("start bit", 1'b0, tx);
        for (int i = 0; i < `UART_DATA_W; i++) begin
            repeat (bit_clks) @(negedge clk);
            check_flag($sformatf("data bit %0d", i), d[i], tx);
        end
        if (parity_mode != uart_frame_pkg::par_none) begin
            repeat (bit_clks) @(negedge clk);
            check_flag("parity bit", expected_parity(parity_mode, d), tx);
        end
        repeat (bit_clks) @(negedge clk);
        check_flag("stop bit", 1'b1, tx);
        if (two_stop) begin
            repeat (bit_clks) @(negedge clk);
            check_flag("second stop bit", 1'b1, tx);
        end
    endtask

    task automatic drive_rx_frame(input uart_frame_pkg::data_t d, input logic bad_parity,
                                  input logic bad_stop);
        rx = 1'b0;
        repeat (bit_clks) @(negedge clk);
        for (int i = 0; i < `UART_DATA_W; i++) begin
            rx = d[i];
            repeat (bit_clks) @(negedge clk);
        end
        if (parity_mode != uart_frame_pkg::par_none) begin
            rx = expected_parity(parity_mode, d) ^ bad_parity;
            repeat (bit_clks) @(negedge clk);
        end
        rx = !bad_stop;   // Only the first stop bit is ever broken
        repeat (bit_clks) @(negedge clk);
        if (two_stop) begin
            rx = 1'b1;
            repeat (bit_clks) @(negedge clk);
        end
        rx = 1'b1;
    endtask

    task automatic run_vector(input int v);
        int                    op;
        int                    nframes;
        int                    target;
        int                    tx_expect;
        int                    cfg;
        uart_frame_pkg::data_t b;
        uart_frame_pkg::data_t sent[$];
        op        = field(v, 0);
        nframes   = field(v, 4);
        test_name = $sformatf("vector %0d op %0d", v, op);
        cfg       = field(v, 1);
        parity_mode = uart_frame_pkg::parity_e'(cfg[2:0]);
        two_stop    = field(v, 2) != 0;
        cfg         = field(v, 3);
        prescaler   = cfg[`UART_PRESCALE_W-1:0];
        bit_clks    = `UART_SAMPLES * (cfg + 1);
        loopback_en = (op == op_loop) || (op == op_overrun);
        reset_dut();
        verify_reset_state();
        cfg = field(v, 5);
        sent.push_back(cfg[`UART_DATA_W-1:0]);
        for (int i = 1; i < nframes; i++) begin
            random_byte(b);
            sent.push_back(b);
        end
        case (op)
            op_loop, op_overrun: begin
                foreach (sent[i])
                    push_byte(sent[i]);
                tx_expect = nframes - 1;   // First byte already taken by the transmitter
                check_level("tx_level after writes", tx_expect[`UART_FIFO_AW:0], tx_level);
                check_flag("tx_full", tx_expect >= 16, tx_full);
                target = nframes > 16 ? 16 : nframes;
                while (rx_level != target[`UART_FIFO_AW:0])
                    @(negedge clk);
                while (ovr_pulses < field(v, 8))
                    @(negedge clk);
                check_flag("rx_full", nframes >= 16, rx_full);
                read_and_compare(sent, target);
            end
            op_line: begin
                foreach (sent[i])
                    push_byte(sent[i]);
                foreach (sent[i])
                    sample_tx_frame(sent[i]);
            end
            default: begin
                drive_rx_frame(sent[0], op == op_err_par, op == op_err_stop);
                while (rx_level == '0)
                    @(negedge clk);
                check_data("received byte", sent[0], rdata);
            end
        endcase
        check_count("parity_error_flag pulses", field(v, 6), par_pulses);
        check_count("frame_error_flag pulses", field(v, 7), frm_pulses);
        check_count("overrun_flag pulses", field(v, 8), ovr_pulses);
    endtask

    initial begin
        int n_vec;
        resetn      = 1'b0;
        en          = 1'b0;
        prescaler   = '0;
        parity_mode = uart_frame_pkg::par_none;
        two_stop    = 1'b0;
        loopback_en = 1'b0;
        wr          = 1'b0;
        wdata       = '0;
        rd          = 1'b0;
        rx          = 1'b1;
        cycles      = 0;
        lfsr        = 32'h5623;
        $readmemh("uart_stimulus.txt", vec_mem);
        n_vec       = 0;
        cycle_limit = 1000;
        while (n_vec < max_vectors && field(n_vec, 0) != 0) begin
            cycle_limit += field(n_vec, 4) * 12 * `UART_SAMPLES * (field(n_vec, 3) + 1) + 100;
            n_vec++;
        end
        if (n_vec == 0)
            stop_on_error("no test vectors found in uart_stimulus.txt");
        for (int v = 0; v < n_vec; v++)
            run_vector(v);
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== uart_baud_gen.sv ====
// Baud prescaler producing one sample tick every prescaler+1 clocks
`timescale 1ns/1ns
`include "uart_config.svh"

module uart_baud_gen (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        en,
    input  logic [`UART_PRESCALE_W-1:0] prescaler,
    output logic                        tick
);

    logic [`UART_PRESCALE_W-1:0] count;
    logic                        wrap;

    assign wrap = count == prescaler;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            count <= '0;
        end else if (en) begin
            count <= wrap ? '0 : count + 1'b1;   // Holds while disabled
        end
    end

    assign tick = en && wrap;

endmodule

// ==== uart_bit_if.sv ====
// Bit strobes between the UART controller and the TX and RX shift registers
`timescale 1ns/1ns

interface tx_bit_if;
    logic                  load;     // Capture FIFO head, also TX FIFO pop
    logic                  shift;    // End of a data bit
    uart_ctrl_pkg::phase_e phase;
    logic                  active;   // Frame on the line

    modport ctrl (
        output load,
        output shift,
        output phase,
        output active
    );
    modport shifter (
        input load,
        input shift,
        input phase,
        input active
    );
endinterface

interface rx_bit_if;
    logic                  line;     // Synchronized serial input
    logic                  sample;   // Middle of the current bit
    uart_ctrl_pkg::phase_e phase;
    logic                  clear;    // Start edge seen
    logic                  done;     // Last stop bit sampled, RX FIFO push

    modport ctrl (
        input  line,
        output sample,
        output phase,
        output clear,
        output done
    );
    modport shifter (
        output line,
        input  sample,
        input  phase,
        input  clear,
        input  done
    );
endinterface

// ==== uart_config.svh ====
// UART build constants for word size, FIFO depth, oversampling and prescaler
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

`define UART_DATA_W      8   // Data bits per frame
`define UART_FIFO_AW     4   // Depth is 2**AW
`define UART_SAMPLES     8   // Ticks per bit
`define UART_PRESCALE_W  16

`endif

// ==== uart_ctrl.sv ====
// UART frame sequencer: TX and RX state machines with sample and bit counters
`timescale 1ns/1ns
`include "uart_config.svh"

module uart_ctrl (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    tick,
    input  logic                    tx_ready,
    input  uart_frame_pkg::parity_e parity_mode,
    input  logic                    two_stop,
    tx_bit_if.ctrl                  tx_bits,
    rx_bit_if.ctrl                  rx_bits
);

    localparam logic [2:0] last_sample = 3'(`UART_SAMPLES - 1);
    localparam logic [2:0] half_sample = 3'(`UART_SAMPLES / 2 - 1);
    localparam logic [2:0] last_bit    = 3'(`UART_DATA_W - 1);

    uart_ctrl_pkg::tx_state_e tx_state;
    uart_ctrl_pkg::rx_state_e rx_state;
    logic [2:0]               tx_scnt;
    logic [2:0]               tx_bcnt;
    logic [2:0]               rx_scnt;
    logic [2:0]               rx_bcnt;
    logic                     has_parity;
    logic                     tx_bit_end;
    logic                     rx_in_bit;

    assign has_parity = parity_mode != uart_frame_pkg::par_none;
    assign tx_bit_end = tick && tx_scnt == last_sample;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            tx_state <= uart_ctrl_pkg::tx_idle;
            tx_scnt  <= '0;
            tx_bcnt  <= '0;
        end else if (tx_state == uart_ctrl_pkg::tx_idle) begin
            tx_scnt <= '0;
            tx_bcnt <= '0;
            if (tx_bits.load)
                tx_state <= uart_ctrl_pkg::tx_start;
        end else if (tx_bit_end) begin
            tx_scnt <= '0;
            case (tx_state)
                uart_ctrl_pkg::tx_start: tx_state <= uart_ctrl_pkg::tx_data;
                uart_ctrl_pkg::tx_data: begin
                    tx_bcnt <= tx_bcnt + 3'd1;
                    if (tx_bcnt == last_bit)
                        tx_state <= has_parity ? uart_ctrl_pkg::tx_parity
                                               : uart_ctrl_pkg::tx_stop0;
                end
                uart_ctrl_pkg::tx_parity: tx_state <= uart_ctrl_pkg::tx_stop0;
                uart_ctrl_pkg::tx_stop0:
                    tx_state <= two_stop ? uart_ctrl_pkg::tx_stop1 : uart_ctrl_pkg::tx_idle;
                default: tx_state <= uart_ctrl_pkg::tx_idle;
            endcase
        end else if (tick) begin
            tx_scnt <= tx_scnt + 3'd1;
        end
    end

    assign tx_bits.load   = tx_state == uart_ctrl_pkg::tx_idle && tx_ready;
    assign tx_bits.shift  = tx_bit_end && tx_state == uart_ctrl_pkg::tx_data;
    assign tx_bits.active = tx_state != uart_ctrl_pkg::tx_idle;

    always_comb begin
        case (tx_state)
            uart_ctrl_pkg::tx_start:  tx_bits.phase = uart_ctrl_pkg::ph_start;
            uart_ctrl_pkg::tx_data:   tx_bits.phase = uart_ctrl_pkg::ph_data;
            uart_ctrl_pkg::tx_parity: tx_bits.phase = uart_ctrl_pkg::ph_parity;
            default:                  tx_bits.phase = uart_ctrl_pkg::ph_stop;   // Idle line high
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rx_state <= uart_ctrl_pkg::rx_idle;
            rx_scnt  <= '0;
            rx_bcnt  <= '0;
        end else begin
            case (rx_state)
                uart_ctrl_pkg::rx_idle: begin
                    rx_scnt <= '0;
                    rx_bcnt <= '0;
                    if (rx_bits.clear)
                        rx_state <= uart_ctrl_pkg::rx_start;
                end
                uart_ctrl_pkg::rx_start: begin
                    if (tick && rx_scnt == half_sample) begin
                        rx_scnt  <= '0;   // Middle of start bit reached
                        rx_state <= rx_bits.line ? uart_ctrl_pkg::rx_idle
                                                 : uart_ctrl_pkg::rx_data;
                    end else if (tick) begin
                        rx_scnt <= rx_scnt + 3'd1;
                    end
                end
                default: begin
                    if (rx_bits.sample) begin
                        rx_scnt <= '0;
                        case (rx_state)
                            uart_ctrl_pkg::rx_data: begin
                                rx_bcnt <= rx_bcnt + 3'd1;
                                if (rx_bcnt == last_bit)
                                    rx_state <= has_parity ? uart_ctrl_pkg::rx_parity
                                                           : uart_ctrl_pkg::rx_stop0;
                            end
                            uart_ctrl_pkg::rx_parity: rx_state <= uart_ctrl_pkg::rx_stop0;
                            uart_ctrl_pkg::rx_stop0:
                                rx_state <= two_stop ? uart_ctrl_pkg::rx_stop1
                                                     : uart_ctrl_pkg::rx_idle;
                            default: rx_state <= uart_ctrl_pkg::rx_idle;
                        endcase
                    end else if (tick) begin
                        rx_scnt <= rx_scnt + 3'd1;
                    end
                end
            endcase
        end
    end

    // Past the start bit, sampling once per bit
    assign rx_in_bit = rx_state != uart_ctrl_pkg::rx_idle && rx_state != uart_ctrl_pkg::rx_start;

    assign rx_bits.sample = rx_in_bit && tick && rx_scnt == last_sample;
    assign rx_bits.clear  = rx_state == uart_ctrl_pkg::rx_idle && tick && !rx_bits.line;
    assign rx_bits.done   = rx_bits.sample && (rx_state == uart_ctrl_pkg::rx_stop1 ||
                            (rx_state == uart_ctrl_pkg::rx_stop0 && !two_stop));

    always_comb begin
        case (rx_state)
            uart_ctrl_pkg::rx_data:   rx_bits.phase = uart_ctrl_pkg::ph_data;
            uart_ctrl_pkg::rx_parity: rx_bits.phase = uart_ctrl_pkg::ph_parity;
            uart_ctrl_pkg::rx_stop0:  rx_bits.phase = uart_ctrl_pkg::ph_stop;
            uart_ctrl_pkg::rx_stop1:  rx_bits.phase = uart_ctrl_pkg::ph_stop;
            default:                  rx_bits.phase = uart_ctrl_pkg::ph_start;
        endcase
    end

endmodule

// ==== uart_ctrl_pkg.sv ====
// Sequencing types of the UART controller: frame states and bit phase
package uart_ctrl_pkg;

    typedef enum logic [2:0] {
        tx_idle, tx_start, tx_data, tx_parity, tx_stop0, tx_stop1
    } tx_state_e;

    typedef enum logic [2:0] {
        rx_idle, rx_start, rx_data, rx_parity, rx_stop0, rx_stop1
    } rx_state_e;

    // Kind of bit currently on the line
    typedef enum logic [1:0] {
        ph_start  = 2'd0,
        ph_data   = 2'd1,
        ph_parity = 2'd2,
        ph_stop   = 2'd3
    } phase_e;

endpackage

// ==== uart_fifo.sv ====
// Synchronous FIFO with fill level and a pulse for writes dropped when full
`timescale 1ns/1ns
`include "uart_config.svh"

module uart_fifo (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    rd,
    input  logic                    wr,
    input  uart_frame_pkg::data_t   wdata,
    output uart_frame_pkg::data_t   rdata,
    output logic                    empty,
    output logic                    full,
    output logic [`UART_FIFO_AW:0]  level,
    output logic                    overflow
);

    localparam int depth = 1 << `UART_FIFO_AW;

    uart_frame_pkg::data_t    mem [depth];
    logic [`UART_FIFO_AW-1:0] wptr;
    logic [`UART_FIFO_AW-1:0] rptr;
    logic                     do_wr;
    logic                     do_rd;

    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wptr] <= wdata;
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wptr  <= '0;
            rptr  <= '0;
            level <= '0;
        end else begin
            if (do_wr)
                wptr <= wptr + 1'b1;
            if (do_rd)
                rptr <= rptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;   // Push and pop together
            endcase
        end
    end

    assign rdata    = mem[rptr];            // Head shown without a read
    assign empty    = level == '0;
    assign full     = level[`UART_FIFO_AW];  // Only set at exactly depth
    assign overflow = wr && full;

endmodule

// ==== uart_frame_pkg.sv ====
// Serial line format of the UART: parity modes, data word and parity rule
`include "uart_config.svh"

package uart_frame_pkg;

    typedef enum logic [2:0] {
        par_none   = 3'b000,
        par_odd    = 3'b001,
        par_even   = 3'b010,
        par_stick0 = 3'b100,
        par_stick1 = 3'b101
    } parity_e;

    typedef logic [`UART_DATA_W-1:0] data_t;

    // Parity bit carried on the line for a given word
    function automatic logic parity_bit(parity_e mode, data_t data);
        case (mode)
            par_odd:    return ~^data;
            par_even:   return ^data;
            par_stick1: return 1'b1;
            default:    return 1'b0;   // Sticky 0, unused for none
        endcase
    endfunction

endpackage

// ==== uart_rx_shifter.sv ====
// UART receive path: input synchronizer, loopback select, shift register, errors
`timescale 1ns/1ns
`include "uart_config.svh"

module uart_rx_shifter (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    rx,
    input  logic                    tx_loop,
    input  logic                    loopback_en,
    input  uart_frame_pkg::parity_e parity_mode,
    rx_bit_if.shifter               bits,
    output uart_frame_pkg::data_t   rdata,
    output logic                    parity_error,
    output logic                    frame_error
);

    logic [1:0]            sync;
    uart_frame_pkg::data_t sreg;
    logic                  par_err;
    logic                  frm_err;
    logic                  stop_bad;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn)
            sync <= 2'b11;
        else
            sync <= {sync[0], rx};
    end

    assign bits.line = loopback_en ? tx_loop : sync[1];   // Loopback skips the sync

    always_ff @(posedge clk) begin
        if (bits.sample && bits.phase == uart_ctrl_pkg::ph_data)
            sreg <= {bits.line, sreg[`UART_DATA_W-1:1]};   // LSB arrives first
    end

    assign stop_bad = bits.sample && bits.phase == uart_ctrl_pkg::ph_stop && !bits.line;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            par_err <= 1'b0;
            frm_err <= 1'b0;
        end else if (bits.clear) begin
            par_err <= 1'b0;
            frm_err <= 1'b0;
        end else begin
            if (bits.sample && bits.phase == uart_ctrl_pkg::ph_parity &&
                bits.line != uart_frame_pkg::parity_bit(parity_mode, sreg))
                par_err <= 1'b1;
            if (stop_bad)
                frm_err <= 1'b1;
        end
    end

    // Last stop bit is judged in the same cycle as done
    assign frame_error  = bits.done && (frm_err || stop_bad);
    assign parity_error = bits.done && par_err;
    assign rdata        = sreg;

endmodule

// ==== uart_stimulus.txt ====
// op parity two_stop prescaler frames first_byte exp_par_pulses exp_frame_pulses exp_overrun
// op: 1 loop, 2 line, 3 err_par, 4 err_stop, 5 overrun, 0 ends the list
1 0 0 0001 04 a5 0 0 0
1 1 0 0001 04 3c 0 0 0
1 2 1 0002 04 81 0 0 0
1 4 0 0001 03 ff 0 0 0
1 5 1 0001 03 00 0 0 0
1 0 1 0003 02 5a 0 0 0
2 0 0 0001 02 b7 0 0 0
2 1 1 0002 02 c4 0 0 0
2 2 0 0001 02 01 0 0 0
2 5 0 0000 01 7e 0 0 0
3 1 0 0001 01 96 1 0 0
3 2 1 0001 01 2d 1 0 0
3 4 0 0002 01 e0 1 0 0
4 0 0 0001 01 c3 0 1 0
4 2 1 0001 01 18 0 1 0
5 0 0 0001 11 42 0 0 1
0 0 0 0000 00 00 0 0 0

// ==== uart_top.sv ====
// UART top level: baud generator, frame control, shifters and two FIFOs
`timescale 1ns/1ns
`include "uart_config.svh"

module uart_top (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        en,
    input  logic [`UART_PRESCALE_W-1:0] prescaler,
    input  uart_frame_pkg::parity_e     parity_mode,
    input  logic                        two_stop,
    input  logic                        loopback_en,
    input  logic                        wr,
    input  uart_frame_pkg::data_t       wdata,
    input  logic                        rd,
    output logic                        tx_empty,
    output logic                        tx_full,
    output logic [`UART_FIFO_AW:0]      tx_level,
    output uart_frame_pkg::data_t       rdata,
    output logic                        rx_empty,
    output logic                        rx_full,
    output logic [`UART_FIFO_AW:0]      rx_level,
    output logic                        parity_error_flag,
    output logic                        frame_error_flag,
    output logic                        overrun_flag,
    input  logic                        rx,
    output logic                        tx
);

    logic                  tick;
    uart_frame_pkg::data_t tx_head;   // Next word to send
    uart_frame_pkg::data_t rx_word;   // Assembled received word

    tx_bit_if tx_bits ();
    rx_bit_if rx_bits ();

    uart_baud_gen baud_gen (
        .clk       (clk),
        .resetn    (resetn),
        .en        (en),
        .prescaler (prescaler),
        .tick      (tick)
    );

    uart_fifo tx_fifo (
        .clk      (clk),
        .resetn   (resetn),
        .rd       (tx_bits.load),
        .wr       (wr),
        .wdata    (wdata),
        .rdata    (tx_head),
        .empty    (tx_empty),
        .full     (tx_full),
        .level    (tx_level),
        .overflow ()
    );

    uart_ctrl ctrl (
        .clk         (clk),
        .resetn      (resetn),
        .tick        (tick),
        .tx_ready    (~tx_empty),
        .parity_mode (parity_mode),
        .two_stop    (two_stop),
        .tx_bits     (tx_bits.ctrl),
        .rx_bits     (rx_bits.ctrl)
    );

    uart_tx_shifter tx_shifter (
        .clk         (clk),
        .resetn      (resetn),
        .bits        (tx_bits.shifter),
        .wdata       (tx_head),
        .parity_mode (parity_mode),
        .tx          (tx)
    );

    uart_rx_shifter rx_shifter (
        .clk          (clk),
        .resetn       (resetn),
        .rx           (rx),
        .tx_loop      (tx),
        .loopback_en  (loopback_en),
        .parity_mode  (parity_mode),
        .bits         (rx_bits.shifter),
        .rdata        (rx_word),
        .parity_error (parity_error_flag),
        .frame_error  (frame_error_flag)
    );

    uart_fifo rx_fifo (
        .clk      (clk),
        .resetn   (resetn),
        .rd       (rd),
        .wr       (rx_bits.done),
        .wdata    (rx_word),
        .rdata    (rdata),
        .empty    (rx_empty),
        .full     (rx_full),
        .level    (rx_level),
        .overflow (overrun_flag)   // Frame lost on a full RX FIFO
    );

endmodule

// ==== uart_tx_shifter.sv ====
// UART transmit shift register with parity generation and registered line
`timescale 1ns/1ns

module uart_tx_shifter (
    input  logic                    clk,
    input  logic                    resetn,
    tx_bit_if.shifter               bits,
    input  uart_frame_pkg::data_t   wdata,
    input  uart_frame_pkg::parity_e parity_mode,
    output logic                    tx
);

    uart_frame_pkg::data_t sreg;
    logic                  par_bit;
    logic                  line;

    always_ff @(posedge clk) begin
        if (bits.load) begin
            sreg    <= wdata;
            par_bit <= uart_frame_pkg::parity_bit(parity_mode, wdata);
        end else if (bits.shift) begin
            sreg <= sreg >> 1;   // LSB first
        end
    end

    always_comb begin
        if (!bits.active) begin
            line = 1'b1;
        end else begin
            case (bits.phase)
                uart_ctrl_pkg::ph_start:  line = 1'b0;
                uart_ctrl_pkg::ph_data:   line = sreg[0];
                uart_ctrl_pkg::ph_parity: line = par_bit;
                default:                  line = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn)
            tx <= 1'b1;   // Line idles high
        else
            tx <= line;
    end

endmodule
